// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= obj_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LOG       ?= sim.log
PASS_MSG  ?= test passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/obj_consts.svh ====
`ifndef OBJ_CONSTS_SVH
`define OBJ_CONSTS_SVH

// Entries in the object table
`define OBJ_COUNT 128

// Lines shown on screen
`define OBJ_VISIBLE_LINES 224

// Bottom value that closes the list
`define OBJ_END_MARK 8'hF0

// Entries per line buffer half
`define OBJ_LINE_W 512

// ROM words per object before the drawer gives up
`define OBJ_MAX_WORDS 64

`endif

// ==== common/obj_pkg.sv ====
`default_nettype none

package obj_pkg;

    // One entry of the line buffer
    // Priority sits on top and colour at the bottom
    typedef struct packed {
        logic [1:0] prio;   // Object priority
        logic [5:0] pal;    // Palette select
        logic [3:0] color;  // Zero is transparent
    } pixel_t;

    // Object table word address
    // Upper 7 bits pick the object and lower 3 bits the word
    typedef logic [9:0] tbl_addr_t;

    // Graphics ROM word address
    // Bank in 18:15 and offset in 14:0
    typedef logic [18:0] rom_addr_t;

endpackage

`default_nettype wire

// ==== obj_scan/obj_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

// Walks the object table at each line start and feeds the drawer
module obj_scan (
    input  wire                clk,
    input  wire                rst,
    input  wire                flip,
    input  wire                hstart,
    input  wire  [8:0]         vrender,
    output obj_pkg::tbl_addr_t tbl_addr,
    input  wire  [15:0]        tbl_dout,
    output logic [15:0]        tbl_din,
    output logic               tbl_we,
    output logic               dr_start,
    input  wire                dr_busy,
    output logic [8:0]         dr_xpos,
    output logic [15:0]        dr_offset,  // Bit 15 is horizontal flip
    output logic [3:0]         dr_bank,
    output logic [1:0]         dr_prio,
    output logic [5:0]         dr_pal
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_NEXT,    // Word 0 address out
        ST_TOP,     // Word 0 back
        ST_XPOS,    // Word 1 back
        ST_PITCH,   // Word 2 back
        ST_BASE,    // Word 3 back
        ST_ATTR,    // Word 4 back
        ST_CALC,    // Word 7 back
        ST_CMD      // Waiting on the drawer
    } st_t;

    st_t         st;
    logic [6:0]  cur_obj;
    logic [2:0]  idx;       // Word being addressed
    logic [9:0]  boot_cnt;  // Waits out the buffer clear
    logic        booted;
    logic [8:0]  vrf;
    logic [7:0]  line_q;    // Line being scanned
    logic        first;     // Top line of the object
    logic [8:0]  xpos;
    logic [15:0] pitch;
    logic [15:0] offset;
    logic [3:0]  bank;
    logic [1:0]  prio;
    logic [5:0]  pal;
    logic [7:0]  top;
    logic [7:0]  bottom;
    logic        inzone;
    logic        last_obj;

    assign tbl_addr = {cur_obj, idx};
    assign tbl_din  = offset;       // Scratch write back
    assign booted   = boot_cnt == 10'(`OBJ_LINE_W);
    assign vrf      = flip ? 9'(`OBJ_VISIBLE_LINES - 1) - vrender : vrender;
    assign top      = tbl_dout[7:0];
    assign bottom   = tbl_dout[15:8];
    assign inzone   = line_q >= top && line_q < bottom;  // Empty when top is not below bottom
    assign last_obj = cur_obj == 7'(`OBJ_COUNT - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= ST_IDLE;
            cur_obj   <= '0;
            idx       <= '0;
            boot_cnt  <= '0;
            line_q    <= '0;
            first     <= 1'b0;
            xpos      <= '0;
            pitch     <= '0;
            offset    <= '0;
            bank      <= '0;
            prio      <= '0;
            pal       <= '0;
            tbl_we    <= 1'b0;
            dr_start  <= 1'b0;
            dr_xpos   <= '0;
            dr_offset <= '0;
            dr_bank   <= '0;
            dr_prio   <= '0;
            dr_pal    <= '0;
        end else begin
            if (!booted) boot_cnt <= boot_cnt + 10'd1;
            tbl_we   <= 1'b0;   // Single cycle writes
            dr_start <= 1'b0;
            if (hstart && booted) begin
                // Restart from object 0 and drop anything pending
                line_q  <= vrf[7:0];
                cur_obj <= '0;
                idx     <= '0;
                st      <= vrf < 9'(`OBJ_VISIBLE_LINES) ? ST_NEXT : ST_IDLE;
            end else begin
                case (st)
                    ST_IDLE: begin
                        cur_obj <= '0;
                        idx     <= '0;
                    end
                    ST_NEXT: begin
                        idx <= 3'd1;
                        st  <= ST_TOP;
                    end
                    ST_TOP: begin
                        if (bottom >= `OBJ_END_MARK) begin
                            st <= ST_IDLE;              // End of list
                        end else if (!inzone) begin
                            if (last_obj) begin
                                st <= ST_IDLE;
                            end else begin
                                cur_obj <= cur_obj + 7'd1;  // Skip it
                                idx     <= '0;
                                st      <= ST_NEXT;
                            end
                        end else begin
                            first <= top == line_q;
                            idx   <= 3'd2;
                            st    <= ST_XPOS;
                        end
                    end
                    ST_XPOS: begin
                        xpos <= tbl_dout[8:0];
                        idx  <= 3'd3;
                        st   <= ST_PITCH;
                    end
                    ST_PITCH: begin
                        pitch <= {{8{tbl_dout[7]}}, tbl_dout[7:0]};  // Sign extend
                        idx   <= 3'd4;
                        st    <= ST_BASE;
                    end
                    ST_BASE: begin
                        offset <= tbl_dout;
                        idx    <= 3'd7;                 // Scratch next
                        st     <= ST_ATTR;
                    end
                    ST_ATTR: begin
                        pal  <= tbl_dout[5:0];
                        prio <= tbl_dout[7:6];
                        bank <= tbl_dout[11:8];
                        st   <= ST_CALC;
                    end
                    ST_CALC: begin
                        // Base on the first line and scratch after that
                        offset <= (first ? offset : tbl_dout) + pitch;
                        tbl_we <= 1'b1;
                        st     <= ST_CMD;
                    end
                    ST_CMD: begin
                        if (!dr_busy) begin
                            dr_xpos   <= xpos;
                            dr_offset <= offset;
                            dr_bank   <= bank;
                            dr_prio   <= prio;
                            dr_pal    <= pal;
                            dr_start  <= 1'b1;
                            if (last_obj) begin
                                st <= ST_IDLE;
                            end else begin
                                cur_obj <= cur_obj + 7'd1;
                                idx     <= '0;
                                st      <= ST_NEXT;
                            end
                        end
                    end
                    default: st <= ST_IDLE;
                endcase
            end
        end
    end

    // Drawer must be free whenever a command goes out
    a_start_free: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> !dr_busy);

    // One write per object
    a_we_pulse: assert property (@(posedge clk) disable iff (rst)
        tbl_we |=> !tbl_we);

endmodule

`default_nettype wire

// ==== obj_scan/obj_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

// Object RAM shared by the CPU and the scanner
module obj_table (
    input  wire obj_pkg::tbl_addr_t cpu_addr,   // CPU side
    input  wire [15:0]              cpu_din,
    input  wire                     cpu_we,
    output logic [15:0]             cpu_dout,
    input  wire obj_pkg::tbl_addr_t tbl_addr,   // Scanner side
    input  wire [15:0]              tbl_din,
    input  wire                     tbl_we,
    output logic [15:0]             tbl_dout,
    input  wire                     clk
);

    // 8 words per object
    logic [15:0] mem [`OBJ_COUNT*8];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_din;   // Scratch word only
        end
        cpu_dout <= mem[cpu_addr];      // One cycle read latency
        tbl_dout <= mem[tbl_addr];
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/obj_pkg.sv
obj_scan/obj_table.sv
obj_scan/obj_scan.sv
src/obj_draw.sv
src/obj_linebuf.sv
src/obj_top.sv
test/obj_tb.sv

// ==== src/obj_draw.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

// Fetches graphics words and writes opaque pixels to the line buffer
module obj_draw (
    input  wire               clk,
    input  wire               rst,
    input  wire               dr_start,
    output logic              dr_busy,
    input  wire  [8:0]        dr_xpos,
    input  wire  [15:0]       dr_offset,
    input  wire  [3:0]        dr_bank,
    input  wire  [1:0]        dr_prio,
    input  wire  [5:0]        dr_pal,
    output logic              rom_cs,
    output obj_pkg::rom_addr_t rom_addr,
    input  wire  [15:0]       rom_data,
    input  wire               rom_ok,
    output logic              buf_we,
    output logic [8:0]        buf_addr,
    output obj_pkg::pixel_t   buf_data
);

    import obj_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,   // Waiting on rom_ok
        ST_PIXEL    // Four nibbles out
    } st_t;

    st_t         st;
    logic [3:0]  bank_q;
    logic [14:0] off_q;
    logic        hflip;
    logic [1:0]  prio_q;
    logic [5:0]  pal_q;
    logic [8:0]  x;
    logic [15:0] data_sr;   // Current ROM word
    logic [1:0]  nib;
    logic [6:0]  words;     // Words fetched so far
    logic [3:0]  col;

    assign rom_addr = {bank_q, off_q};
    assign col      = hflip ? data_sr[3:0] : data_sr[15:12];  // Low nibble first when flipped

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= ST_IDLE;
            dr_busy  <= 1'b0;
            rom_cs   <= 1'b0;
            buf_we   <= 1'b0;
            buf_addr <= '0;
            buf_data <= '0;
            bank_q   <= '0;
            off_q    <= '0;
            hflip    <= 1'b0;
            prio_q   <= '0;
            pal_q    <= '0;
            x        <= '0;
            data_sr  <= '0;
            nib      <= '0;
            words    <= '0;
        end else begin
            buf_we <= 1'b0;
            case (st)
                ST_IDLE: begin
                    if (dr_start) begin
                        bank_q  <= dr_bank;
                        off_q   <= dr_offset[14:0];
                        hflip   <= dr_offset[15];
                        prio_q  <= dr_prio;
                        pal_q   <= dr_pal;
                        x       <= dr_xpos;
                        words   <= '0;
                        dr_busy <= 1'b1;
                        rom_cs  <= 1'b1;
                        st      <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (rom_ok) begin
                        rom_cs  <= 1'b0;
                        data_sr <= rom_data;
                        nib     <= '0;
                        words   <= words + 7'd1;
                        off_q   <= hflip ? off_q - 15'd1 : off_q + 15'd1;  // Walk backwards on flip
                        st      <= ST_PIXEL;
                    end
                end
                ST_PIXEL: begin
                    data_sr <= hflip ? data_sr >> 4 : data_sr << 4;
                    nib     <= nib + 2'd1;
                    x       <= x + 9'd1;
                    if (col == 4'hf) begin
                        dr_busy <= 1'b0;                // End marker
                        st      <= ST_IDLE;
                    end else begin
                        if (col != 4'h0) begin
                            buf_we   <= 1'b1;
                            buf_addr <= x;
                            buf_data <= pixel_t'{prio: prio_q, pal: pal_q, color: col};
                        end
                        if (nib == 2'd3) begin
                            if (words == 7'(`OBJ_MAX_WORDS)) begin
                                dr_busy <= 1'b0;        // Runaway object
                                st      <= ST_IDLE;
                            end else begin
                                rom_cs <= 1'b1;
                                st     <= ST_FETCH;
                            end
                        end
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    // Request held until the ROM answers
    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr));

endmodule

`default_nettype wire

// ==== src/obj_linebuf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

// Double line buffer: one half drawn while the other is shown
module obj_linebuf (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  hstart,
    input  wire                  buf_we,
    input  wire  [8:0]           buf_addr,
    input  wire obj_pkg::pixel_t buf_data,
    input  wire  [8:0]           hdump,
    output obj_pkg::pixel_t      pix
);

    import obj_pkg::*;

    pixel_t      half0 [`OBJ_LINE_W];
    pixel_t      half1 [`OBJ_LINE_W];
    logic        sel;           // Half being drawn
    logic        sweep_on;      // Clearing after reset
    logic [8:0]  sweep_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel       <= 1'b0;
            sweep_on  <= 1'b1;
            sweep_cnt <= '0;
        end else begin
            if (sweep_on) begin
                sweep_cnt <= sweep_cnt + 9'd1;
                if (sweep_cnt == 9'(`OBJ_LINE_W - 1)) sweep_on <= 1'b0;
            end else if (hstart) begin
                sel <= ~sel;                    // Swap halves
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sweep_on) begin
            half0[sweep_cnt] <= '0;
            half1[sweep_cnt] <= '0;
        end else if (sel) begin
            if (buf_we) half1[buf_addr] <= buf_data;
            half0[hdump] <= '0;                 // Clear behind the read
        end else begin
            if (buf_we) half0[buf_addr] <= buf_data;
            half1[hdump] <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix <= '0;
        end else begin
            pix <= sel ? half0[hdump] : half1[hdump];   // Display half
        end
    end

endmodule

`default_nettype wire

// ==== src/obj_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Object engine: table, scanner, drawer and line buffer
module obj_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire obj_pkg::tbl_addr_t cpu_addr,
    input  wire  [15:0]             cpu_din,
    input  wire                     cpu_we,
    output wire  [15:0]             cpu_dout,
    input  wire                     flip,
    input  wire                     hstart,
    input  wire  [8:0]              vrender,
    input  wire  [8:0]              hdump,
    output wire                     rom_cs,
    output wire obj_pkg::rom_addr_t rom_addr,
    input  wire  [15:0]             rom_data,
    input  wire                     rom_ok,
    output wire obj_pkg::pixel_t    pix
);

    import obj_pkg::*;

    wire tbl_addr_t tbl_addr;   // Scanner port of the table
    wire [15:0]     tbl_din;
    wire [15:0]     tbl_dout;
    wire            tbl_we;
    wire            dr_start;   // Draw command
    wire            dr_busy;
    wire [8:0]      dr_xpos;
    wire [15:0]     dr_offset;
    wire [3:0]      dr_bank;
    wire [1:0]      dr_prio;
    wire [5:0]      dr_pal;
    wire            buf_we;     // Line buffer write
    wire [8:0]      buf_addr;
    wire pixel_t    buf_data;

    obj_table u_table (
        .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_we(cpu_we), .cpu_dout(cpu_dout),
        .tbl_addr(tbl_addr), .tbl_din(tbl_din), .tbl_we(tbl_we), .tbl_dout(tbl_dout),
        .clk(clk)
    );

    obj_scan u_scan (
        .clk(clk), .rst(rst), .flip(flip), .hstart(hstart), .vrender(vrender),
        .tbl_addr(tbl_addr), .tbl_dout(tbl_dout), .tbl_din(tbl_din), .tbl_we(tbl_we),
        .dr_start(dr_start), .dr_busy(dr_busy), .dr_xpos(dr_xpos), .dr_offset(dr_offset),
        .dr_bank(dr_bank), .dr_prio(dr_prio), .dr_pal(dr_pal)
    );

    obj_draw u_draw (
        .clk(clk), .rst(rst),
        .dr_start(dr_start), .dr_busy(dr_busy), .dr_xpos(dr_xpos), .dr_offset(dr_offset),
        .dr_bank(dr_bank), .dr_prio(dr_prio), .dr_pal(dr_pal),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_data(buf_data)
    );

    obj_linebuf u_linebuf (
        .clk(clk), .rst(rst), .hstart(hstart),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_data(buf_data),
        .hdump(hdump), .pix(pix)
    );

endmodule

`default_nettype wire

// ==== test/obj_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_tb;

    import obj_pkg::*;

    localparam int CLK_NS    = 40;
    localparam int LINE_CYC  = 1200;     // Cycles between hstart pulses
    localparam int ROM_WORDS = 4096;     // Banks 0 to 3, 1K words each
    localparam logic [8:0] NO_LINE = 9'd300;  // Never a visible line, flipped or not

    logic        clk;
    logic        rst;
    tbl_addr_t   cpu_addr;
    logic [15:0] cpu_din;
    logic        cpu_we;
    logic [15:0] cpu_dout;
    logic        flip;
    logic        hstart;
    logic [8:0]  vrender;
    logic [8:0]  hdump;
    logic        rom_cs;
    rom_addr_t   rom_addr;
    logic [15:0] rom_data;
    logic        rom_ok;
    pixel_t      pix;

    logic [15:0] rom [ROM_WORDS];
    pixel_t      cap_line [`OBJ_LINE_W];    // Last line read back on pix
    pixel_t      exp_line [`OBJ_LINE_W];
    logic [31:0] stim_lfsr;
    logic [31:0] rom_lfsr;                  // Own state for the ROM latency
    int          errors;
    int          tests_run;

    obj_top DUT (
        .clk(clk), .rst(rst),
        .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_we(cpu_we), .cpu_dout(cpu_dout),
        .flip(flip), .hstart(hstart), .vrender(vrender), .hdump(hdump),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .pix(pix)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);   // One step per bit
            v = {v[14:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [11:0] rom_index(input rom_addr_t a);
        return {a[16:15], a[9:0]};
    endfunction

    function automatic logic [15:0] line_off(input logic [15:0] base, input logic [7:0] pitch,
                                             input int k);
        logic [15:0] o;
        o = base;
        for (int i = 0; i <= k; i++) o = o + {{8{pitch[7]}}, pitch};  // k+1 pitch steps
        return o;
    endfunction

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    // Random nibbles, colour 15 only where placed
    task automatic fill_rom();
        logic [3:0] nib;
        for (int a = 0; a < ROM_WORDS; a++) begin
            for (int n = 0; n < 4; n++) begin
                nib = 4'(rand_bits(4));
                if (nib == 4'hf) nib = 4'h0;
                rom[a][n*4 +: 4] = nib;
            end
            if (a % 8 == 5) rom[a][7:4] = 4'hf;   // Keeps every object short
        end
    endtask

    // Variable latency ROM
    initial begin : rom_model
        logic [1:0] wait_bits;
        rom_ok   = 1'b0;
        rom_data = '0;
        rom_lfsr = 32'hf92a;
        forever begin
            tick();
            rom_ok = 1'b0;
            if (rom_cs) begin
                rom_lfsr = lfsr_next(rom_lfsr);
                wait_bits[1] = rom_lfsr[0];
                rom_lfsr = lfsr_next(rom_lfsr);
                wait_bits[0] = rom_lfsr[0];
                repeat (int'(wait_bits) % 3) tick();   // 1 to 3 cycles in all
                rom_data = rom[rom_index(rom_addr)];
                rom_ok   = 1'b1;
            end
        end
    end

    task automatic cpu_write(input tbl_addr_t a, input logic [15:0] d);
        cpu_addr = a;
        cpu_din  = d;
        cpu_we   = 1'b1;
        tick();
        cpu_we   = 1'b0;
    endtask

    task automatic cpu_read(input tbl_addr_t a, output logic [15:0] d);
        cpu_addr = a;
        tick();
        d = cpu_dout;   // Registered read
    endtask

    task automatic put_obj(input int n, input logic [7:0] top, input logic [7:0] bottom,
                           input logic [8:0] x, input logic [7:0] pitch,
                           input logic [15:0] base, input logic [3:0] bank,
                           input logic [1:0] pr, input logic [5:0] pl);
        cpu_write({7'(n), 3'd0}, {bottom, top});
        cpu_write({7'(n), 3'd1}, {7'd0, x});
        cpu_write({7'(n), 3'd2}, {8'd0, pitch});
        cpu_write({7'(n), 3'd3}, base);
        cpu_write({7'(n), 3'd4}, {4'd0, bank, pr, pl});
    endtask

    task automatic end_list(input int n);
        cpu_write({7'(n), 3'd0}, {`OBJ_END_MARK, 8'h00});
    endtask

    task automatic clear_exp();
        for (int k = 0; k < `OBJ_LINE_W; k++) exp_line[k] = '0;
    endtask

    // Expected pixels of one draw command
    task automatic paint(input logic [8:0] xpos, input logic [15:0] off, input logic [3:0] bank,
                         input logic [1:0] pr, input logic [5:0] pl);
        logic [14:0] a;
        logic [8:0]  x;
        logic [15:0] w;
        logic [3:0]  c;
        logic        stop;
        a    = off[14:0];
        x    = xpos;
        stop = 1'b0;
        for (int i = 0; i < `OBJ_MAX_WORDS && !stop; i++) begin
            w = rom[rom_index({bank, a})];
            for (int n = 0; n < 4 && !stop; n++) begin
                c = off[15] ? w[n*4 +: 4] : w[12 - n*4 +: 4];  // Flip reads low nibble first
                if (c == 4'hf) begin
                    stop = 1'b1;
                end else begin
                    if (c != 4'h0) exp_line[x] = pixel_t'{prio: pr, pal: pl, color: c};
                    x = x + 9'd1;
                end
            end
            a = off[15] ? a - 15'd1 : a + 15'd1;
        end
    endtask

    // One video line: hstart, then hdump sweep that captures the previous line
    task automatic run_line(input logic [8:0] vr, input logic fl);
        vrender = vr;
        flip    = fl;
        hstart  = 1'b1;
        hdump   = '0;
        tick();
        hstart  = 1'b0;
        for (int k = 0; k < `OBJ_LINE_W; k++) begin
            hdump = 9'(k);
            tick();
            cap_line[k] = pix;  // One cycle behind hdump
        end
        hdump = '0;
        repeat (LINE_CYC - `OBJ_LINE_W - 1) tick();
        if (rom_cs) begin
            errors++;
            $display("error at %0t ns: the drawer was still fetching at the end of the line",
                     $time);
        end
    endtask

    task automatic compare_line(input bit need_pixels);
        int shown;
        int opaque;
        shown  = 0;
        opaque = 0;
        for (int k = 0; k < `OBJ_LINE_W; k++) begin
            if (exp_line[k].color != 4'h0) opaque++;
            if (cap_line[k] !== exp_line[k]) begin
                errors++;
                if (shown < 8) begin
                    $display("error at %0t ns: pix[%0d] is %h, expected %h",
                             $time, k, 12'(cap_line[k]), 12'(exp_line[k]));
                end
                shown++;
            end
        end
        if (need_pixels && opaque == 0) begin
            errors++;
            $display("error at %0t ns: the expected line holds no visible pixel", $time);
        end
    endtask

    task automatic report(input string name, input int e0);
        tests_run++;
        if (errors == e0) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - e0);
    endtask

    // Eight objects on line 100, odd ones flipped
    task automatic row_obj(input int i, output logic [8:0] x, output logic [7:0] pitch,
                           output logic [15:0] base, output logic [3:0] bank,
                           output logic [1:0] pr, output logic [5:0] pl);
        x     = 9'(20 + 60 * i);
        pitch = 8'(i + 1);
        base  = {i[0], 15'(256 + 80 * i)};
        bank  = 4'(i % 4);
        pr    = 2'(i);
        pl    = 6'(i * 5);
    endtask

    task automatic put_row();
        logic [8:0]  x;
        logic [7:0]  pitch;
        logic [15:0] base;
        logic [3:0]  bank;
        logic [1:0]  pr;
        logic [5:0]  pl;
        for (int i = 0; i < 8; i++) begin
            row_obj(i, x, pitch, base, bank, pr, pl);
            put_obj(i, 8'd100, 8'd110, x, pitch, base, bank, pr, pl);
        end
        end_list(8);
    endtask

    task automatic paint_row();
        logic [8:0]  x;
        logic [7:0]  pitch;
        logic [15:0] base;
        logic [3:0]  bank;
        logic [1:0]  pr;
        logic [5:0]  pl;
        clear_exp();
        for (int i = 0; i < 8; i++) begin
            row_obj(i, x, pitch, base, bank, pr, pl);
            paint(x, line_off(base, pitch, 0), bank, pr, pl);
        end
    endtask

    task automatic table_access();
        logic [15:0] wr [112];
        logic [15:0] rd;
        int          e0;
        e0 = errors;
        for (int i = 0; i < 112; i++) begin
            wr[i] = rand_bits(16);
            cpu_write({7'(i / 7), 3'(i % 7)}, wr[i]);   // Words 0 to 6 of 16 objects
        end
        for (int i = 0; i < 112; i++) begin
            cpu_read({7'(i / 7), 3'(i % 7)}, rd);
            if (rd !== wr[i]) begin
                errors++;
                $display("error at %0t ns: cpu_dout is %h, expected %h", $time, rd, wr[i]);
            end
        end
        report("table access", e0);
    endtask

    task automatic single_object();
        int e0;
        e0 = errors;
        put_obj(0, 8'd40, 8'd60, 9'd100, 8'd8, 16'h0100, 4'd1, 2'd2, 6'd5);
        end_list(1);
        clear_exp();
        paint(9'd100, line_off(16'h0100, 8'd8, 0), 4'd1, 2'd2, 6'd5);
        run_line(9'd40, 1'b0);
        run_line(NO_LINE, 1'b0);
        compare_line(1'b1);
        report("single object", e0);
    endtask

    task automatic pitch_advance();
        logic [15:0] rd;
        int          e0;
        e0 = errors;
        put_obj(0, 8'd80, 8'd90, 9'd200, 8'd5, 16'h0200, 4'd2, 2'd1, 6'd9);
        put_obj(1, 8'd80, 8'd90, 9'd300, 8'hfd, 16'h0400, 4'd0, 2'd3, 6'd17);  // Pitch -3
        end_list(2);
        run_line(9'd80, 1'b0);
        for (int k = 0; k < 4; k++) begin
            clear_exp();
            paint(9'd200, line_off(16'h0200, 8'd5, k), 4'd2, 2'd1, 6'd9);
            paint(9'd300, line_off(16'h0400, 8'hfd, k), 4'd0, 2'd3, 6'd17);
            run_line(k < 3 ? 9'(81 + k) : NO_LINE, 1'b0);   // Shows line 80+k
            compare_line(1'b1);
        end
        cpu_read({7'd1, 3'd7}, rd);
        if (rd !== line_off(16'h0400, 8'hfd, 3)) begin
            errors++;
            $display("error at %0t ns: scratch word is %h, expected %h",
                     $time, rd, line_off(16'h0400, 8'hfd, 3));
        end
        report("pitch advance", e0);
    endtask

    task automatic selection_rules();
        int e0;
        e0 = errors;
        put_obj(0, 8'd50, 8'd60, 9'd20, 8'd1, 16'h0010, 4'd0, 2'd0, 6'd1);    // Above line 70
        put_obj(1, 8'd60, 8'd50, 9'd60, 8'd1, 16'h0020, 4'd0, 2'd0, 6'd2);    // Top past bottom
        put_obj(2, 8'd70, 8'd80, 9'd100, 8'd2, 16'h0030, 4'd1, 2'd0, 6'd3);
        put_obj(3, 8'd70, 8'd75, 9'd108, 8'd3, 16'h0040, 4'd2, 2'd1, 6'd4);   // Overlaps 2
        end_list(4);
        put_obj(5, 8'd70, 8'd80, 9'd300, 8'd1, 16'h0050, 4'd3, 2'd2, 6'd6);   // Past the end
        clear_exp();
        paint(9'd100, line_off(16'h0030, 8'd2, 0), 4'd1, 2'd0, 6'd3);
        paint(9'd108, line_off(16'h0040, 8'd3, 0), 4'd2, 2'd1, 6'd4);
        run_line(9'd70, 1'b0);
        run_line(NO_LINE, 1'b0);
        compare_line(1'b1);
        report("selection rules", e0);
    endtask

    task automatic flip_and_stall();
        int e0;
        e0 = errors;
        put_obj(0, 8'd20, 8'd30, 9'd50, 8'd4, 16'h8300, 4'd3, 2'd2, 6'd33);  // Mirrored
        end_list(1);
        clear_exp();
        paint(9'd50, line_off(16'h8300, 8'd4, 0), 4'd3, 2'd2, 6'd33);
        run_line(9'd20, 1'b0);
        run_line(NO_LINE, 1'b0);
        compare_line(1'b1);
        put_row();
        paint_row();
        run_line(9'd100, 1'b0);
        run_line(NO_LINE, 1'b0);
        compare_line(1'b1);
        run_line(9'd123, 1'b1);     // Flipped screen, still line 100
        run_line(NO_LINE, 1'b0);
        compare_line(1'b1);
        report("flip and back-pressure", e0);
    endtask

    task automatic clear_after_read();
        int e0;
        e0 = errors;
        put_row();
        paint_row();
        run_line(9'd100, 1'b0);
        run_line(NO_LINE, 1'b0);
        compare_line(1'b1);
        clear_exp();
        run_line(NO_LINE, 1'b0);    // Other half, nothing drawn
        compare_line(1'b0);
        run_line(NO_LINE, 1'b0);    // Row half again, read out already
        compare_line(1'b0);
        report("clear after read", e0);
    endtask

    initial begin : watchdog
        #(6 * 8 * LINE_CYC * CLK_NS);
        $display("timeout: the tests did not complete in the expected time");
        $display("test failed");
        $finish;
    end

    initial begin : main
        cpu_addr  = '0;
        cpu_din   = '0;
        cpu_we    = 1'b0;
        flip      = 1'b0;
        hstart    = 1'b0;
        vrender   = '0;
        hdump     = '0;
        stim_lfsr = 32'hf92a;
        errors    = 0;
        tests_run = 0;
        rst       = 1'b1;
        fill_rom();
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        repeat (`OBJ_LINE_W + 16) tick();   // Buffer clear sweep
        table_access();
        single_object();
        pitch_advance();
        selection_rules();
        flip_and_stall();
        clear_after_read();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
